// File: rtl/otp_scrmbl.sv
//////////////////////////////////////////////////////////////////////
// OTP scrambling datapath top: control, working registers and one
// iterative PRESENT-128 round
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "scrmbl_consts.svh"

module otp_scrmbl (
  input  wire logic                       clk_i,
  input  wire logic                       rst_ni,
  input  wire scrmbl_pkg::scrmbl_cmd_e    cmd_i,
  input  wire logic [`SCRMBL_SEL_W-1:0]   sel_i,
  input  wire logic [`SCRMBL_BLOCK_W-1:0] data_i,
  input  wire logic                       valid_i,
  output logic                            ready_o,
  output logic                            valid_o,
  output logic      [`SCRMBL_BLOCK_W-1:0] data_o
);

  scrmbl_pkg::data_sel_e      data_sel;
  scrmbl_pkg::key_sel_e       key_sel;
  logic                       data_en, key_en, shadow_load, digest_en, digest_init;
  logic [`SCRMBL_CNT_W-1:0]   round_idx;
  logic                       last_round;
  logic [`SCRMBL_BLOCK_W-1:0] data_q, round_data;
  logic [`SCRMBL_KEY_W-1:0]   key_q, round_key;

  scrmbl_ctrl u_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cmd_i         (cmd_i),
    .valid_i       (valid_i),
    .ready_o       (ready_o),
    .valid_o       (valid_o),
    .data_sel_o    (data_sel),
    .key_sel_o     (key_sel),
    .data_en_o     (data_en),
    .key_en_o      (key_en),
    .shadow_load_o (shadow_load),
    .digest_en_o   (digest_en),
    .digest_init_o (digest_init),
    .round_idx_o   (round_idx),
    .last_round_o  (last_round)
  );

  scrmbl_state u_state (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .sel_i         (sel_i),
    .data_i        (data_i),
    .data_sel_i    (data_sel),
    .key_sel_i     (key_sel),
    .data_en_i     (data_en),
    .key_en_i      (key_en),
    .shadow_load_i (shadow_load),
    .digest_en_i   (digest_en),
    .digest_init_i (digest_init),
    .round_data_i  (round_data),
    .round_key_i   (round_key),
    .data_q_o      (data_q),
    .key_q_o       (key_q)
  );

  present_round u_round (
    .data_i       (data_q),
    .key_i        (key_q),
    .round_idx_i  (round_idx),
    .last_round_i (last_round),
    .data_o       (round_data),
    .key_o        (round_key)
  );

  // result only leaves the block together with the valid pulse
  assign data_o = valid_o ? data_q : '0;

endmodule

`default_nettype wire

// File: rtl/present_round.sv
//////////////////////////////////////////////////////////////////////
// one combinational PRESENT-128 encryption round with key schedule
// the final whitening is folded in when last_round_i is set
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "scrmbl_consts.svh"

module present_round (
  input  wire logic [`SCRMBL_BLOCK_W-1:0] data_i,
  input  wire logic [`SCRMBL_KEY_W-1:0]   key_i,
  input  wire logic [`SCRMBL_CNT_W-1:0]   round_idx_i,
  input  wire logic                       last_round_i,
  output logic      [`SCRMBL_BLOCK_W-1:0] data_o,
  output logic      [`SCRMBL_KEY_W-1:0]   key_o
);

  // 4-bit PRESENT s-box
  function automatic logic [3:0] sbox4(input logic [3:0] x);
    logic [3:0] y;
    unique case (x)
      4'h0: y = 4'hc;
      4'h1: y = 4'h5;
      4'h2: y = 4'h6;
      4'h3: y = 4'hb;
      4'h4: y = 4'h9;
      4'h5: y = 4'h0;
      4'h6: y = 4'ha;
      4'h7: y = 4'hd;
      4'h8: y = 4'h3;
      4'h9: y = 4'he;
      4'ha: y = 4'hf;
      4'hb: y = 4'h8;
      4'hc: y = 4'h4;
      4'hd: y = 4'h7;
      4'he: y = 4'h1;
      default: y = 4'h2;
    endcase
    return y;
  endfunction

  logic [`SCRMBL_BLOCK_W-1:0] key_added;
  logic [`SCRMBL_BLOCK_W-1:0] sbox_out;
  logic [`SCRMBL_BLOCK_W-1:0] perm_out;
  logic [`SCRMBL_KEY_W-1:0]   key_rot;

  ////////////////////////////////////////////////////////////////////
  // data path
  ////////////////////////////////////////////////////////////////////

  // round key is the upper half of the key register
  assign key_added = data_i ^ key_i[`SCRMBL_KEY_W-1 -: `SCRMBL_BLOCK_W];

  always_comb begin
    for (int i = 0; i < `SCRMBL_BLOCK_W / 4; i++) begin
      sbox_out[4*i +: 4] = sbox4(key_added[4*i +: 4]);
    end
    // bit j moves to 16*(j mod 4) + j/4
    for (int j = 0; j < `SCRMBL_BLOCK_W; j++) begin
      perm_out[16*(j%4) + j/4] = sbox_out[j];
    end
  end

  ////////////////////////////////////////////////////////////////////
  // key schedule
  ////////////////////////////////////////////////////////////////////

  // rotate left by 61
  assign key_rot = {key_i[66:0], key_i[127:67]};

  always_comb begin
    key_o          = key_rot;
    key_o[127:124] = sbox4(key_rot[127:124]);
    key_o[123:120] = sbox4(key_rot[123:120]);
    // round counter goes into bits 66..62
    key_o[66:62]   = key_rot[66:62] ^ round_idx_i;
  end

  // after round 31 the next round key whitens the output
  assign data_o = last_round_i ? (perm_out ^ key_o[`SCRMBL_KEY_W-1 -: `SCRMBL_BLOCK_W]) :
                                 perm_out;

endmodule

`default_nettype wire

// File: rtl/scrmbl_consts.svh
//////////////////////////////////////////////////////////////////////
// widths, round count and fixed secrets of the OTP scrambling datapath
// include wherever a width or a key constant is needed
//////////////////////////////////////////////////////////////////////

`ifndef SCRMBL_CONSTS_SVH
`define SCRMBL_CONSTS_SVH

// block and key sizes of PRESENT-128
`define SCRMBL_BLOCK_W      64
`define SCRMBL_KEY_W        128

// key / constant select
`define SCRMBL_SEL_W        1

// full PRESENT round count and width of the round index
`define SCRMBL_NUM_ROUNDS   31
`define SCRMBL_CNT_W        5

// scrambling keys, key 0 is zero so the published test vector applies
`define SCRMBL_KEY0         128'h0000_0000_0000_0000_0000_0000_0000_0000
`define SCRMBL_KEY1         128'h3a5c_91e7_04bd_6f28_c1d9_7e30_5ab4_f612

// digest IV and finalization key
`define SCRMBL_DIGEST_IV    64'h7d2f_4a91_c3e8_0b56
`define SCRMBL_DIGEST_CONST 128'h5e83_b0c4_29fa_71d6_8c1b_e047_93a5_2f6d

`endif

// File: rtl/scrmbl_ctrl.sv
//////////////////////////////////////////////////////////////////////
// command decoder and round sequencer of the scrambling datapath
// drives mux selects and register enables for the state stage
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "scrmbl_consts.svh"

module scrmbl_ctrl (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  input  wire scrmbl_pkg::scrmbl_cmd_e   cmd_i,
  input  wire logic                      valid_i,
  output logic                           ready_o,
  output logic                           valid_o,
  output scrmbl_pkg::data_sel_e          data_sel_o,
  output scrmbl_pkg::key_sel_e           key_sel_o,
  output logic                           data_en_o,
  output logic                           key_en_o,
  output logic                           shadow_load_o,
  output logic                           digest_en_o,
  output logic                           digest_init_o,
  output logic [`SCRMBL_CNT_W-1:0]       round_idx_o,
  output logic                           last_round_o
);

  scrmbl_pkg::scrmbl_state_e state_d, state_q;
  logic [`SCRMBL_CNT_W-1:0]  cnt_d, cnt_q;
  logic                      valid_d, valid_q;

  // counter runs 1..31 through the rounds, then wraps to 0 for the
  // hand-back cycle
  assign round_idx_o  = cnt_q;
  assign last_round_o = (cnt_q == `SCRMBL_CNT_W'(`SCRMBL_NUM_ROUNDS));
  assign ready_o      = (state_q == scrmbl_pkg::IdleSt);
  assign valid_o      = valid_q;

  ////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    cnt_d         = cnt_q;
    valid_d       = 1'b0;
    data_sel_o    = scrmbl_pkg::SelDataInput;
    key_sel_o     = scrmbl_pkg::SelDigestInput;
    data_en_o     = 1'b0;
    key_en_o      = 1'b0;
    shadow_load_o = 1'b0;
    digest_en_o   = 1'b0;
    digest_init_o = 1'b0;

    unique case (state_q)
      scrmbl_pkg::IdleSt: begin
        if (valid_i) begin
          unique case (cmd_i)
            scrmbl_pkg::Encrypt: begin
              state_d   = scrmbl_pkg::EncryptSt;
              cnt_d     = `SCRMBL_CNT_W'(1);
              key_sel_o = scrmbl_pkg::SelKeyInit;
              data_en_o = 1'b1;
              key_en_o  = 1'b1;
            end
            // single-cycle commands, no rounds and no valid_o
            scrmbl_pkg::LoadShadow: shadow_load_o = 1'b1;
            scrmbl_pkg::DigestInit: digest_init_o = 1'b1;
            // digest state is the plaintext, {data_i, shadow} the key
            scrmbl_pkg::Digest: begin
              state_d    = scrmbl_pkg::DigestSt;
              cnt_d      = `SCRMBL_CNT_W'(1);
              data_sel_o = scrmbl_pkg::SelDigestState;
              data_en_o  = 1'b1;
              key_en_o   = 1'b1;
            end
            scrmbl_pkg::DigestFinalize: begin
              state_d    = scrmbl_pkg::DigestSt;
              cnt_d      = `SCRMBL_CNT_W'(1);
              data_sel_o = scrmbl_pkg::SelDigestState;
              key_sel_o  = scrmbl_pkg::SelDigestConst;
              data_en_o  = 1'b1;
              key_en_o   = 1'b1;
            end
            default: ;
          endcase
        end
      end
      scrmbl_pkg::EncryptSt, scrmbl_pkg::DigestSt: begin
        if (cnt_q == '0) begin
          // result is settled in the data register
          state_d = scrmbl_pkg::IdleSt;
          valid_d = 1'b1;
        end else begin
          data_sel_o = scrmbl_pkg::SelRoundOut;
          key_sel_o  = scrmbl_pkg::SelRoundKey;
          data_en_o  = 1'b1;
          key_en_o   = 1'b1;
          cnt_d      = cnt_q + 1'b1;
          // Davies-Meyer feed-forward on the last digest round
          if (last_round_o && state_q == scrmbl_pkg::DigestSt) begin
            data_sel_o  = scrmbl_pkg::SelRoundOutXor;
            digest_en_o = 1'b1;
          end
        end
      end
      default: state_d = scrmbl_pkg::IdleSt;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= scrmbl_pkg::IdleSt;
      cnt_q   <= '0;
      valid_q <= 1'b0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      valid_q <= valid_d;
    end
  end

endmodule

`default_nettype wire

// File: rtl/scrmbl_pkg.sv
//////////////////////////////////////////////////////////////////////
// enum types shared by the scrambling datapath and its testbench
//////////////////////////////////////////////////////////////////////

`default_nettype none

package scrmbl_pkg;

  // commands accepted on cmd_i
  typedef enum logic [2:0] {
    Encrypt        = 3'd0,
    LoadShadow     = 3'd1,
    DigestInit     = 3'd2,
    Digest         = 3'd3,
    DigestFinalize = 3'd4
  } scrmbl_cmd_e;

  // control FSM states
  typedef enum logic [1:0] {
    IdleSt    = 2'd0,
    EncryptSt = 2'd1,
    DigestSt  = 2'd2
  } scrmbl_state_e;

  // next value of the data working register
  typedef enum logic [1:0] {
    SelRoundOut    = 2'd0,
    SelRoundOutXor = 2'd1,
    SelDigestState = 2'd2,
    SelDataInput   = 2'd3
  } data_sel_e;

  // next value of the key working register
  typedef enum logic [1:0] {
    SelRoundKey    = 2'd0,
    SelKeyInit     = 2'd1,
    SelDigestConst = 2'd2,
    SelDigestInput = 2'd3
  } key_sel_e;

endpackage

`default_nettype wire

// File: rtl/scrmbl_state.sv
//////////////////////////////////////////////////////////////////////
// working registers of the scrambling datapath: key, data, shadow
// and digest state, with their input muxes and constant tables
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "scrmbl_consts.svh"

module scrmbl_state (
  input  wire logic                       clk_i,
  input  wire logic                       rst_ni,
  input  wire logic [`SCRMBL_SEL_W-1:0]   sel_i,
  input  wire logic [`SCRMBL_BLOCK_W-1:0] data_i,
  input  wire scrmbl_pkg::data_sel_e      data_sel_i,
  input  wire scrmbl_pkg::key_sel_e       key_sel_i,
  input  wire logic                       data_en_i,
  input  wire logic                       key_en_i,
  input  wire logic                       shadow_load_i,
  input  wire logic                       digest_en_i,
  input  wire logic                       digest_init_i,
  input  wire logic [`SCRMBL_BLOCK_W-1:0] round_data_i,
  input  wire logic [`SCRMBL_KEY_W-1:0]   round_key_i,
  output logic      [`SCRMBL_BLOCK_W-1:0] data_q_o,
  output logic      [`SCRMBL_KEY_W-1:0]   key_q_o
);

  // scrambling key table, indexed by sel_i
  localparam logic [`SCRMBL_KEY_W-1:0] KeyLut [2**`SCRMBL_SEL_W] =
      '{`SCRMBL_KEY0, `SCRMBL_KEY1};

  logic [`SCRMBL_BLOCK_W-1:0] data_d, data_q;
  logic [`SCRMBL_BLOCK_W-1:0] shadow_q;
  logic [`SCRMBL_BLOCK_W-1:0] digest_q;
  logic [`SCRMBL_BLOCK_W-1:0] round_xor;
  logic [`SCRMBL_KEY_W-1:0]   key_d, key_q;
  logic [`SCRMBL_KEY_W-1:0]   key_init;
  logic [`SCRMBL_KEY_W-1:0]   digest_key;

  assign key_init   = KeyLut[sel_i];
  // 128-bit digest block, shadow holds the lower half
  assign digest_key = {data_i, shadow_q};
  // feed-forward for the one-way compression
  assign round_xor  = round_data_i ^ digest_q;

  ////////////////////////////////////////////////////////////////////
  // input muxes
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (data_sel_i)
      scrmbl_pkg::SelRoundOut:    data_d = round_data_i;
      scrmbl_pkg::SelRoundOutXor: data_d = round_xor;
      scrmbl_pkg::SelDigestState: data_d = digest_q;
      default:                    data_d = data_i;
    endcase
  end

  always_comb begin
    unique case (key_sel_i)
      scrmbl_pkg::SelRoundKey:    key_d = round_key_i;
      scrmbl_pkg::SelKeyInit:     key_d = key_init;
      scrmbl_pkg::SelDigestConst: key_d = `SCRMBL_DIGEST_CONST;
      default:                    key_d = digest_key;
    endcase
  end

  ////////////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      data_q   <= '0;
      key_q    <= '0;
      shadow_q <= '0;
      digest_q <= '0;
    end else begin
      if (data_en_i) begin
        data_q <= data_d;
      end
      if (key_en_i) begin
        key_q <= key_d;
      end
      if (shadow_load_i) begin
        shadow_q <= data_i;
      end
      // IV load wins over a digest update
      if (digest_init_i) begin
        digest_q <= `SCRMBL_DIGEST_IV;
      end else if (digest_en_i) begin
        digest_q <= round_xor;
      end
    end
  end

  assign data_q_o = data_q;
  assign key_q_o  = key_q;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the scrambler testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing -f tb.f --top-module tb_otp_scrmbl -o tb_otp_scrmbl &&
./obj_dir/tb_otp_scrmbl || exit 1

// File: tb.f
+incdir+rtl
+incdir+testbench
rtl/scrmbl_pkg.sv
rtl/present_round.sv
rtl/scrmbl_ctrl.sv
rtl/scrmbl_state.sv
rtl/otp_scrmbl.sv
testbench/tb_otp_scrmbl.sv

// File: testbench/scrmbl_stim.txt
# columns: name command sel data expected
# command encrypt/shadow/init/digest/final, data hex or rand, expected hex, model or -
kat_zero     encrypt 0 0000000000000000 96db702a2e6900af
enc_key1_a   encrypt 1 rand             model
enc_key1_b   encrypt 1 rand             model
dig_init     init    0 0                -
dig_shadow   shadow  0 0123456789abcdef -
dig_update   digest  0 fedcba9876543210 model
enc_between  encrypt 0 rand             model
dig_final    final   0 0                model
b2b_shadow   shadow  1 rand             -
b2b_init     init    0 rand             -
b2b_update   digest  0 rand             model
b2b_final    final   1 0                model

// File: testbench/tb_present_model.svh
//////////////////////////////////////////////////////////////////////
// behavioral PRESENT-128 encryption and Davies-Meyer compression
// included inside the testbench module as a reference model
//////////////////////////////////////////////////////////////////////

`ifndef TB_PRESENT_MODEL_SVH
`define TB_PRESENT_MODEL_SVH

// s-box lookup, entry x sits in nibble x of the table word
function automatic logic [3:0] nibble_sub(input logic [3:0] x);
  logic [63:0] table_v;
  table_v = 64'h2174_8fe3_da09_b65c;
  return table_v[{x, 2'b00} +: 4];
endfunction

// bit i goes to 16*i mod 63, bit 63 stays put
function automatic logic [`SCRMBL_BLOCK_W-1:0] bit_spread(input logic [`SCRMBL_BLOCK_W-1:0] s);
  logic [`SCRMBL_BLOCK_W-1:0] p;
  int dst;
  p = '0;
  for (int i = 0; i < `SCRMBL_BLOCK_W; i++) begin
    dst = (i == 63) ? 63 : (i * 16) % 63;
    p[dst] = s[i];
  end
  return p;
endfunction

// 128-bit key register update for round counter rc
function automatic logic [`SCRMBL_KEY_W-1:0] next_key(input logic [`SCRMBL_KEY_W-1:0] k,
                                                      input logic [4:0] rc);
  logic [`SCRMBL_KEY_W-1:0] r;
  r = (k << 61) | (k >> 67);
  r[127:124] = nibble_sub(r[127:124]);
  r[123:120] = nibble_sub(r[123:120]);
  r[66:62] = r[66:62] ^ rc;
  return r;
endfunction

function automatic logic [`SCRMBL_BLOCK_W-1:0] present_encrypt(
    input logic [`SCRMBL_KEY_W-1:0] key, input logic [`SCRMBL_BLOCK_W-1:0] pt);
  logic [`SCRMBL_BLOCK_W-1:0] s;
  logic [`SCRMBL_KEY_W-1:0] k;
  s = pt;
  k = key;
  for (int r = 1; r <= `SCRMBL_NUM_ROUNDS; r++) begin
    s = s ^ k[127:64];
    for (int n = 0; n < `SCRMBL_BLOCK_W / 4; n++) begin
      s[4*n +: 4] = nibble_sub(s[4*n +: 4]);
    end
    s = bit_spread(s);
    k = next_key(k, 5'(r));
  end
  // final whitening with round key 32
  return s ^ k[127:64];
endfunction

// one-way compression, chaining value fed forward
function automatic logic [`SCRMBL_BLOCK_W-1:0] davies_meyer(
    input logic [`SCRMBL_KEY_W-1:0] key, input logic [`SCRMBL_BLOCK_W-1:0] h);
  return present_encrypt(key, h) ^ h;
endfunction

`endif

// File: testbench/tb_otp_scrmbl.sv
//////////////////////////////////////////////////////////////////////
// testbench of the OTP scrambling datapath, replays the stim file
// and checks every result against the PRESENT reference model
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "scrmbl_consts.svh"

module tb_otp_scrmbl;

  localparam int TokW     = 8 * 24;
  localparam int MaxLines = 32;
  localparam int DriveDly = 2;

  logic                       clk_i;
  logic                       rst_ni;
  scrmbl_pkg::scrmbl_cmd_e    cmd_i;
  logic [`SCRMBL_SEL_W-1:0]   sel_i;
  logic [`SCRMBL_BLOCK_W-1:0] data_i;
  logic                       valid_i;
  logic                       ready_o;
  logic                       valid_o;
  logic [`SCRMBL_BLOCK_W-1:0] data_o;

  // one entry per stim line
  logic [TokW-1:0]            names [MaxLines];
  scrmbl_pkg::scrmbl_cmd_e    cmds [MaxLines];
  logic [`SCRMBL_SEL_W-1:0]   sels [MaxLines];
  logic [`SCRMBL_BLOCK_W-1:0] datas [MaxLines];
  logic [`SCRMBL_BLOCK_W-1:0] exp_vals [MaxLines];
  logic                       use_model [MaxLines];

  int     num_lines;
  int     cycles = 0;
  int     cycle_limit = 1000;
  integer seed;
  // model copies of shadow and digest registers
  logic [`SCRMBL_BLOCK_W-1:0] shadow_m, digest_m, exp_v;

  `include "tb_present_model.svh"

  otp_scrmbl u_dut (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .cmd_i   (cmd_i),
    .sel_i   (sel_i),
    .data_i  (data_i),
    .valid_i (valid_i),
    .ready_o (ready_o),
    .valid_o (valid_o),
    .data_o  (data_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////////////////////////
  // reporting and compares
  //////////////////////////////////////////////////////////////////////

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_data(input logic [TokW-1:0] name,
                            input logic [`SCRMBL_BLOCK_W-1:0] exp,
                            input logic [`SCRMBL_BLOCK_W-1:0] act);
    if (act !== exp) begin
      stop_run($sformatf("FAIL %0s data_o expected %016h actual %016h", name, exp, act));
    end
  endtask

  // valid_o and ready_o levels of one cycle
  task automatic check_cmd_done(input logic [TokW-1:0] name,
                                input logic exp_valid, input logic exp_ready,
                                input logic act_valid, input logic act_ready);
    if (act_valid !== exp_valid || act_ready !== exp_ready) begin
      stop_run($sformatf("FAIL %0s valid_o,ready_o expected %b,%b actual %b,%b",
                         name, exp_valid, exp_ready, act_valid, act_ready));
    end
  endtask

  // timeout scaled by the number of stim lines
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      stop_run($sformatf("timeout, run still busy after %0d clock cycles", cycles));
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stim file parsing
  //////////////////////////////////////////////////////////////////////

  task automatic parse_hex(input logic [TokW-1:0] tok, output logic [`SCRMBL_BLOCK_W-1:0] val);
    logic [7:0] ch;
    logic [3:0] nib;
    val = '0;
    for (int i = TokW / 8 - 1; i >= 0; i--) begin
      ch = tok[8*i +: 8];
      if (ch == 8'h00 || ch == "_") continue;
      if (ch >= "0" && ch <= "9") begin
        nib = 4'(ch - "0");
      end else if (ch >= "a" && ch <= "f") begin
        nib = 4'(ch - "a" + 8'd10);
      end else begin
        stop_run("stim file holds a value that is not hex");
      end
      val = {val[`SCRMBL_BLOCK_W-5:0], nib};
    end
  endtask

  task automatic decode_cmd(input logic [TokW-1:0] tok, output scrmbl_pkg::scrmbl_cmd_e c);
    c = scrmbl_pkg::Encrypt;
    if (tok == TokW'("encrypt")) c = scrmbl_pkg::Encrypt;
    else if (tok == TokW'("shadow")) c = scrmbl_pkg::LoadShadow;
    else if (tok == TokW'("init")) c = scrmbl_pkg::DigestInit;
    else if (tok == TokW'("digest")) c = scrmbl_pkg::Digest;
    else if (tok == TokW'("final")) c = scrmbl_pkg::DigestFinalize;
    else stop_run("stim file holds an unknown command word");
  endtask

  task automatic read_stim();
    int fd;
    int cnt;
    int sel_v;
    logic [8*160-1:0] line;
    logic [TokW-1:0] t_name, t_cmd, t_data, t_exp;
    fd = $fopen("testbench/scrmbl_stim.txt", "r");
    if (fd == 0) stop_run("cannot open testbench/scrmbl_stim.txt");
    num_lines = 0;
    while ($fgets(line, fd) > 0) begin
      t_name = '0;
      cnt = $sscanf(line, "%s %s %d %s %s", t_name, t_cmd, sel_v, t_data, t_exp);
      // blank and comment lines
      if (cnt <= 0 || t_name == TokW'("#")) continue;
      if (cnt != 5) stop_run("stim file line does not have five fields");
      if (num_lines == MaxLines) stop_run("stim file has too many lines");
      names[num_lines] = t_name;
      decode_cmd(t_cmd, cmds[num_lines]);
      sels[num_lines] = sel_v[`SCRMBL_SEL_W-1:0];
      if (t_data == TokW'("rand")) begin
        datas[num_lines] = {$random(seed), $random(seed)};
      end else begin
        parse_hex(t_data, datas[num_lines]);
      end
      use_model[num_lines] = (t_exp == TokW'("model"));
      exp_vals[num_lines] = '0;
      if (!use_model[num_lines] && t_exp != TokW'("-")) begin
        parse_hex(t_exp, exp_vals[num_lines]);
      end
      num_lines++;
    end
    $fclose(fd);
  endtask

  //////////////////////////////////////////////////////////////////////
  // driver
  //////////////////////////////////////////////////////////////////////

  task automatic run_line(input int n);
    logic multi;
    multi = (cmds[n] != scrmbl_pkg::LoadShadow) && (cmds[n] != scrmbl_pkg::DigestInit);
    // expected result from the model
    case (cmds[n])
      scrmbl_pkg::Encrypt:
        exp_v = present_encrypt((sels[n] == 1'b1) ? `SCRMBL_KEY1 : `SCRMBL_KEY0, datas[n]);
      scrmbl_pkg::LoadShadow: shadow_m = datas[n];
      scrmbl_pkg::DigestInit: digest_m = `SCRMBL_DIGEST_IV;
      scrmbl_pkg::Digest: begin
        digest_m = davies_meyer({datas[n], shadow_m}, digest_m);
        exp_v = digest_m;
      end
      scrmbl_pkg::DigestFinalize: begin
        digest_m = davies_meyer(`SCRMBL_DIGEST_CONST, digest_m);
        exp_v = digest_m;
      end
      default: ;
    endcase
    if (!use_model[n]) exp_v = exp_vals[n];
    valid_i = 1'b1;
    cmd_i = cmds[n];
    sel_i = sels[n];
    data_i = datas[n];
    @(posedge clk_i);
    #DriveDly;
    if (multi) begin
      // a digest reset offered during the rounds must be ignored
      cmd_i = scrmbl_pkg::DigestInit;
      // 31 round cycles and the hand-back cycle
      repeat (`SCRMBL_NUM_ROUNDS + 1) begin
        data_i = {$random(seed), $random(seed)};
        check_cmd_done(names[n], 1'b0, 1'b0, valid_o, ready_o);
        check_data(names[n], '0, data_o);
        @(posedge clk_i);
        #DriveDly;
      end
      valid_i = 1'b0;
      // result on the 32nd edge after acceptance
      check_cmd_done(names[n], 1'b1, 1'b1, valid_o, ready_o);
      check_data(names[n], exp_v, data_o);
    end else begin
      check_cmd_done(names[n], 1'b0, 1'b1, valid_o, ready_o);
      check_data(names[n], '0, data_o);
    end
  endtask

  initial begin
    seed = 4;
    rst_ni = 1'b0;
    valid_i = 1'b0;
    cmd_i = scrmbl_pkg::Encrypt;
    sel_i = '0;
    data_i = '0;
    shadow_m = '0;
    digest_m = '0;
    exp_v = '0;
    read_stim();
    cycle_limit = 40 * num_lines + 20;
    repeat (2) @(posedge clk_i);
    #DriveDly;
    rst_ni = 1'b1;
    check_cmd_done(TokW'("reset"), 1'b0, 1'b1, valid_o, ready_o);
    check_data(TokW'("reset"), '0, data_o);
    for (int n = 0; n < num_lines; n++) begin
      run_line(n);
    end
    valid_i = 1'b0;
    // valid_o is a single-cycle pulse
    @(posedge clk_i);
    #DriveDly;
    check_cmd_done(TokW'("end"), 1'b0, 1'b1, valid_o, ready_o);
    check_data(TokW'("end"), '0, data_o);
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire
